// ==== testbench/fp_mul_cases.txt ====
// columns: rs1 rs2 rm expected_rd expected_fflags
// rm 0..4 is rne rtz rdn rup rmm, fflags bits are nv dz of uf nx
3F800000 3F800000 0 3F800000 00
3FC00000 3FC00000 0 40100000 00
// sticky only, each directed mode
3F800001 3F800001 0 3F800002 01
3F800001 3F800001 1 3F800002 01
3F800001 3F800001 3 3F800003 01
BF800001 3F800001 2 BF800003 01
BF800001 3F800001 3 BF800002 01
// ties
3F800001 3FC00000 0 3FC00002 01
3F800003 3FC00000 0 3FC00004 01
3F800003 3FC00000 4 3FC00005 01
// rounding carries into the exponent
3FB504F3 3FB504F3 0 3FFFFFFF 01
3FB504F3 3FB504F3 3 40000000 01
BFB504F3 3FB504F3 2 C0000000 01
// special operands
7F800000 00000000 0 7FC00000 10
7F800001 3F800000 0 7FC00000 10
7FC00001 3F800000 0 7FC00000 00
FF800000 40000000 0 FF800000 00
00000000 C0400000 0 80000000 00
// overflow and underflow
7F000000 40000000 0 7F800000 05
7F000000 40000000 1 7F7FFFFF 05
FF000000 40000000 3 FF7FFFFF 05
FF000000 40000000 2 FF800000 05
00800000 3F000000 0 00000000 03
80800000 3F000000 0 80000000 03
// subnormal operands
00400000 40800000 0 01000000 00
40800000 00400000 0 01000000 00
00000003 7E800001 0 34C00002 01
00400000 00400000 0 00000000 03

// ==== flist.f ====
hdl/fp_mul_pkg.sv
hdl/fp_operand_classify.sv
hdl/clz.sv
hdl/fp_operand_prenormalize.sv
hdl/unsigned_multiplier.sv
hdl/fp_mul_core.sv
hdl/fp_norm_round.sv
hdl/fp_mul_unit.sv
testbench/fp_mul_tb.sv

// ==== testbench/fp_mul_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_mul_tb;
  import fp_mul_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 4;
  localparam int DRIVE_DELAY = 2;
  localparam int MAX_CASES = 64;
  localparam int WORDS_PER_CASE = 5;
  localparam int PIPE_DEPTH = 3;
  // the accepting edge loads mul1, done follows the third register load
  localparam int LATENCY_EDGES = 3;

  logic clk;
  logic rst_n;
  fp_issue_t issue;
  logic new_request;
  logic ready;
  fp_wb_t wb;
  logic done;
  logic ack;

  // five words per case: rs1, rs2, rm, rd, fflags
  logic [31:0] case_words [0:MAX_CASES*WORDS_PER_CASE-1];
  int num_cases;
  int checked_count;
  int current_case;
  int seed;
  int pending[$];

  fp_mul_unit #(.ENABLE_SUBNORMAL(1'b1)) DUT (
    .clk(clk),
    .rst_n(rst_n),
    .issue(issue),
    .new_request(new_request),
    .ready(ready),
    .wb(wb),
    .done(done),
    .ack(ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////
  // reporting and compare tasks
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rd(input int idx, input logic [FLEN-1:0] got,
                          input logic [FLEN-1:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("ERR %0t: case %0d rd is %h, expected %h",
                          $time, idx, got, expected));
    end
  endtask

  task automatic check_flags(input int idx, input fp_flags_t got, input fp_flags_t expected);
    if (got !== expected) begin
      abort_run($sformatf("ERR %0t: case %0d fflags are %b, expected %b",
                          $time, idx, got, expected));
    end
  endtask

  task automatic check_id(input int idx, input logic [ID_WIDTH-1:0] got,
                          input logic [ID_WIDTH-1:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("ERR %0t: case %0d id is %0d, expected %0d",
                          $time, idx, got, expected));
    end
  endtask

  task automatic drive_request(input int idx);
    issue.rs1 = case_words[idx*WORDS_PER_CASE];
    issue.rs2 = case_words[idx*WORDS_PER_CASE+1];
    issue.rm = fp_rm_e'(case_words[idx*WORDS_PER_CASE+2][2:0]);
    issue.id = ID_WIDTH'(idx % 8);
    current_case = idx;
    new_request = 1'b1;
  endtask

  //////////////////////////////
  // writeback monitor
  initial begin
    fp_wb_t held_wb;
    logic held_valid;
    int idx;
    held_valid = 1'b0;
    forever begin
      @(posedge clk);
      if (rst_n === 1'b1) begin
        // ready may only drop with a full pipe that is stalled
        if (ready !== ((pending.size() < PIPE_DEPTH) || ack)) begin
          abort_run($sformatf("ready was %b with %0d requests in flight at %0t",
                              ready, pending.size(), $time));
        end
        if (done === 1'b1) begin
          if (held_valid && (wb !== held_wb)) begin
            abort_run($sformatf("writeback changed while waiting for ack at %0t", $time));
          end
          if (ack) begin
            if (pending.size() == 0) begin
              abort_run($sformatf("a result came back with no request outstanding at %0t",
                                  $time));
            end
            idx = pending.pop_front();
            check_rd(idx, wb.rd, case_words[idx*WORDS_PER_CASE+3]);
            check_flags(idx, wb.fflags, fp_flags_t'(case_words[idx*WORDS_PER_CASE+4][4:0]));
            check_id(idx, wb.id, ID_WIDTH'(idx % 8));
            checked_count++;
            held_valid = 1'b0;
          end else begin
            held_valid = 1'b1;
            held_wb = wb;
          end
        end else begin
          held_valid = 1'b0;
        end
        if (new_request && ready) begin
          pending.push_back(current_case);
        end
      end
    end
  end

  // run budget scales with the number of cases
  initial begin
    wait (num_cases > 0);
    #((num_cases * 20 + RESET_CYCLES) * CLK_PERIOD);
    abort_run($sformatf("timeout: only %0d of %0d results came back in time",
                        checked_count, num_cases));
  end

  //////////////////////////////
  // stimulus
  initial begin
    int next_case;
    int gap;
    int edges;
    logic accepted;

    rst_n = 1'b0;
    issue = '0;
    new_request = 1'b0;
    ack = 1'b0;
    seed = 948;
    checked_count = 0;
    current_case = 0;

    $readmemh("testbench/fp_mul_cases.txt", case_words);
    num_cases = 0;
    while (num_cases < MAX_CASES && !$isunknown(case_words[num_cases*WORDS_PER_CASE])) begin
      num_cases++;
    end
    if (num_cases <= PIPE_DEPTH) begin
      abort_run("the cases file is missing or holds too few cases");
    end

    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (i > 0 && (done !== 1'b0 || ready !== 1'b1)) begin
        abort_run("during reset done should be low and ready high");
      end
    end
    rst_n = 1'b1;

    @(posedge clk);
    #DRIVE_DELAY;
    if (done !== 1'b0 || ready !== 1'b1) begin
      abort_run("after reset done should be low and ready high");
    end

    // single request with ack held high to measure latency
    ack = 1'b1;
    drive_request(0);
    do begin
      @(posedge clk);
      accepted = new_request && ready;
    end while (!accepted);
    #DRIVE_DELAY;
    new_request = 1'b0;
    edges = 1;
    while (done !== 1'b1) begin
      @(posedge clk);
      #DRIVE_DELAY;
      edges++;
    end
    if (edges != LATENCY_EDGES) begin
      abort_run($sformatf("ERR %0t: done rose %0d edges after accept, expected %0d",
                          $time, edges, LATENCY_EDGES));
    end
    while (checked_count < 1) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end

    // hold ack low so the next three requests fill the pipe
    ack = 1'b0;
    for (int i = 1; i <= PIPE_DEPTH; i++) begin
      drive_request(i);
      do begin
        @(posedge clk);
        accepted = new_request && ready;
      end while (!accepted);
      #DRIVE_DELAY;
      new_request = 1'b0;
    end
    if (ready !== 1'b0 || done !== 1'b1) begin
      abort_run("with three requests held and no ack, ready should be low and done high");
    end

    // remaining cases with random gaps and random back-pressure
    next_case = PIPE_DEPTH + 1;
    gap = 0;
    while (checked_count < num_cases) begin
      @(posedge clk);
      accepted = new_request && ready;
      #DRIVE_DELAY;
      ack = ($unsigned($random(seed)) % 4) != 0;
      if (accepted) begin
        new_request = 1'b0;
        next_case++;
        gap = $unsigned($random(seed)) % 3;
      end
      if (!new_request && next_case < num_cases) begin
        if (gap == 0) begin
          drive_request(next_case);
        end else begin
          gap--;
        end
      end
    end

    // nothing else may come out
    ack = 1'b1;
    repeat (4) begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (done !== 1'b0 || pending.size() != 0) begin
        abort_run("an extra result appeared after all cases were checked");
      end
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/fp_mul_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_mul_unit #(
  parameter bit ENABLE_SUBNORMAL = 1'b1
) (
  input  logic clk,
  input  logic rst_n,
  input  fp_mul_pkg::fp_issue_t issue,
  input  logic new_request,
  output logic ready,
  output fp_mul_pkg::fp_wb_t wb,
  output logic done,
  input  logic ack
);
  import fp_mul_pkg::*;

  fp_pre_round_t pre_round;
  logic [FLEN-1:0] result_rd;
  fp_flags_t result_flags;
  logic [ID_WIDTH-1:0] result_id;

  fp_mul_core #(.ENABLE_SUBNORMAL(ENABLE_SUBNORMAL)) core (
    .clk(clk),
    .rst_n(rst_n),
    .issue(issue),
    .new_request(new_request),
    .ready(ready),
    .ack(ack),
    .done(done),
    .id(result_id),
    .pre_round(pre_round)
  );

  // rounding sits after the output register, so wb stays stable under back-pressure
  fp_norm_round norm_round (
    .pre_round(pre_round),
    .rd(result_rd),
    .fflags(result_flags)
  );

  assign wb = '{rd: result_rd, fflags: result_flags, id: result_id};

endmodule

`default_nettype wire

// ==== hdl/fp_norm_round.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_norm_round (
  input  fp_mul_pkg::fp_pre_round_t pre_round,
  output logic [fp_mul_pkg::FLEN-1:0] rd,
  output fp_mul_pkg::fp_flags_t fflags
);
  import fp_mul_pkg::*;

  localparam int EXPO_ALL_ONES = 2**EXPO_WIDTH - 1;

  logic signed [EXPO_EXT_WIDTH-1:0] expo_norm;
  logic signed [EXPO_EXT_WIDTH-1:0] expo_rnd;
  logic [SIG_WIDTH-1:0] sig_norm;
  logic [SIG_WIDTH:0] sig_sum;
  logic [FRAC_WIDTH-1:0] frac_rnd;
  logic guard;
  logic sticky;
  logic inexact;
  logic round_up;
  logic overflow;
  logic underflow;
  logic max_finite;

  // safe bit set means the product is in [2,4)
  always_comb begin
    if (pre_round.frac[SIG_WIDTH]) begin
      sig_norm = pre_round.frac[SIG_WIDTH:1];
      guard = pre_round.frac[0];
      sticky = |pre_round.grs;
      expo_norm = pre_round.expo + EXPO_EXT_WIDTH'(1);
    end else begin
      sig_norm = pre_round.frac[SIG_WIDTH-1:0];
      guard = pre_round.grs[2];
      sticky = |pre_round.grs[1:0];
      expo_norm = pre_round.expo;
    end
  end

  assign inexact = guard | sticky;

  always_comb begin
    case (pre_round.rm)
      RNE: round_up = guard & (sticky | sig_norm[0]);
      RMM: round_up = guard;
      RUP: round_up = ~pre_round.sign & inexact;
      RDN: round_up = pre_round.sign & inexact;
      default: round_up = 1'b0;
    endcase
  end

  // carry out of the significand bumps the exponent
  assign sig_sum = {1'b0, sig_norm} + (SIG_WIDTH + 1)'(round_up);
  assign frac_rnd = sig_sum[SIG_WIDTH] ? sig_sum[FRAC_WIDTH:1] : sig_sum[FRAC_WIDTH-1:0];
  assign expo_rnd = expo_norm + EXPO_EXT_WIDTH'(sig_sum[SIG_WIDTH]);

  assign overflow = ~expo_rnd[EXPO_EXT_WIDTH-1] &
                    (expo_rnd[EXPO_EXT_WIDTH-2:0] >= EXPO_ALL_ONES);
  assign underflow = expo_rnd[EXPO_EXT_WIDTH-1] | (expo_rnd == '0);

  // directed modes that round toward zero saturate at the largest finite value
  assign max_finite = (pre_round.rm == RTZ) |
                      ((pre_round.rm == RDN) & ~pre_round.sign) |
                      ((pre_round.rm == RUP) & pre_round.sign);

  always_comb begin
    fflags = '0;
    if (pre_round.special) begin
      rd = pre_round.special_result;
      fflags.nv = pre_round.invalid;
    end else if (overflow) begin
      if (max_finite) begin
        rd = {pre_round.sign, {(EXPO_WIDTH-1){1'b1}}, 1'b0, {FRAC_WIDTH{1'b1}}};
      end else begin
        rd = {pre_round.sign, {EXPO_WIDTH{1'b1}}, {FRAC_WIDTH{1'b0}}};
      end
      fflags.of = 1'b1;
      fflags.nx = 1'b1;
    end else if (underflow) begin
      // flush to signed zero
      rd = {pre_round.sign, {(FLEN-1){1'b0}}};
      fflags.uf = 1'b1;
      fflags.nx = 1'b1;
    end else begin
      rd = {pre_round.sign, expo_rnd[EXPO_WIDTH-1:0], frac_rnd};
      fflags.nx = inexact;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fp_mul_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_mul_core #(
  parameter bit ENABLE_SUBNORMAL = 1'b1
) (
  input  logic clk,
  input  logic rst_n,
  input  fp_mul_pkg::fp_issue_t issue,
  input  logic new_request,
  output logic ready,
  input  logic ack,
  output logic done,
  output logic [fp_mul_pkg::ID_WIDTH-1:0] id,
  output fp_mul_pkg::fp_pre_round_t pre_round
);
  import fp_mul_pkg::*;

  fp_class_t rs1_cls;
  fp_class_t rs2_cls;
  logic [FLEN-1:0] swapped_rs1;
  logic [FLEN-1:0] swapped_rs2;
  logic [SIG_WIDTH-1:0] rs1_sig;
  logic [SIG_WIDTH-1:0] rs2_sig;
  logic [EXPO_WIDTH-1:0] rs2_shift;
  logic [2*SIG_WIDTH-1:0] product;

  logic [2:0] valid;
  logic [2:0] advance;

  logic sign_s0;
  logic invalid_s0;
  logic nan_s0;
  logic special_s0;
  logic [FLEN-1:0] special_result_s0;
  logic [EXPO_WIDTH-1:0] rs1_expo_s0;
  logic [EXPO_WIDTH-1:0] rs2_expo_s0;

  logic [ID_WIDTH-1:0] s1_id;
  fp_rm_e s1_rm;
  logic s1_sign;
  logic [EXPO_WIDTH-1:0] s1_rs1_expo;
  logic [EXPO_WIDTH-1:0] s1_rs2_expo;
  logic [EXPO_WIDTH-1:0] s1_shift;
  logic s1_special;
  logic [FLEN-1:0] s1_special_result;
  logic s1_invalid;
  logic signed [EXPO_EXT_WIDTH-1:0] expo_s1;

  logic [ID_WIDTH-1:0] s2_id;
  fp_rm_e s2_rm;
  logic s2_sign;
  logic signed [EXPO_EXT_WIDTH-1:0] s2_expo;
  logic s2_special;
  logic [FLEN-1:0] s2_special_result;
  logic s2_invalid;
  fp_pre_round_t pre_round_d;

  //////////////////////////////
  // operand decode
  fp_operand_classify #(.ENABLE_SUBNORMAL(ENABLE_SUBNORMAL)) rs1_classify (
    .operand(issue.rs1),
    .cls(rs1_cls)
  );

  fp_operand_classify #(.ENABLE_SUBNORMAL(ENABLE_SUBNORMAL)) rs2_classify (
    .operand(issue.rs2),
    .cls(rs2_cls)
  );

  fp_operand_prenormalize prenormalize (
    .rs1(issue.rs1),
    .rs2(issue.rs2),
    .rs1_cls(rs1_cls),
    .rs2_cls(rs2_cls),
    .swapped_rs1(swapped_rs1),
    .swapped_rs2(swapped_rs2),
    .rs1_frac(rs1_sig),
    .rs2_frac(rs2_sig),
    .rs2_shift(rs2_shift)
  );

  // subnormals carry an effective exponent of 1
  assign rs1_expo_s0 = (swapped_rs1[FLEN-2 -: EXPO_WIDTH] == '0) ? EXPO_WIDTH'(1) :
                       swapped_rs1[FLEN-2 -: EXPO_WIDTH];
  assign rs2_expo_s0 = (swapped_rs2[FLEN-2 -: EXPO_WIDTH] == '0) ? EXPO_WIDTH'(1) :
                       swapped_rs2[FLEN-2 -: EXPO_WIDTH];

  //////////////////////////////
  // special cases
  assign sign_s0 = issue.rs1[FLEN-1] ^ issue.rs2[FLEN-1];
  assign invalid_s0 = (rs1_cls.inf & rs2_cls.zero) | (rs1_cls.zero & rs2_cls.inf) |
                      rs1_cls.snan | rs2_cls.snan;
  assign nan_s0 = invalid_s0 | rs1_cls.qnan | rs2_cls.qnan;

  // inf times zero is already caught as a NaN above
  always_comb begin
    special_s0 = 1'b1;
    if (nan_s0) begin
      special_result_s0 = CANONICAL_NAN;
    end else if (rs1_cls.inf | rs2_cls.inf) begin
      special_result_s0 = {sign_s0, {EXPO_WIDTH{1'b1}}, {FRAC_WIDTH{1'b0}}};
    end else if (rs1_cls.zero | rs2_cls.zero) begin
      special_result_s0 = {sign_s0, {(FLEN-1){1'b0}}};
    end else begin
      special_s0 = 1'b0;
      special_result_s0 = '0;
    end
  end

  //////////////////////////////
  // stall chain
  assign advance[2] = ack | ~valid[2];
  assign advance[1] = ~valid[1] | advance[2];
  assign advance[0] = ~valid[0] | advance[1];
  assign ready = advance[0];
  assign done = valid[2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= '0;
    end else begin
      if (advance[0]) valid[0] <= new_request;
      if (advance[1]) valid[1] <= valid[0];
      if (advance[2]) valid[2] <= valid[1];
    end
  end

  unsigned_multiplier #(.WIDTH(SIG_WIDTH)) sig_mul (
    .clk(clk),
    .rst_n(rst_n),
    .advance1(advance[0]),
    .advance2(advance[1]),
    .rs1(rs1_sig),
    .rs2(rs2_sig),
    .out(product)
  );

  // biased exponent, corrected for the pre-normalize shift
  assign expo_s1 = EXPO_EXT_WIDTH'(s1_rs1_expo) + EXPO_EXT_WIDTH'(s1_rs2_expo) -
                   EXPO_EXT_WIDTH'(BIAS) - EXPO_EXT_WIDTH'(s1_shift);

  // top 25 bits keep safe and hidden, the rest folds into grs
  always_comb begin
    pre_round_d.sign = s2_sign;
    pre_round_d.expo = s2_expo;
    pre_round_d.frac = product[2*SIG_WIDTH-1 -: SIG_WIDTH+1];
    pre_round_d.grs = {product[FRAC_WIDTH-1], product[FRAC_WIDTH-2], |product[FRAC_WIDTH-3:0]};
    pre_round_d.rm = s2_rm;
    pre_round_d.special = s2_special;
    pre_round_d.special_result = s2_special_result;
    pre_round_d.invalid = s2_invalid;
  end

  always_ff @(posedge clk) begin
    // mul1
    if (advance[0]) begin
      s1_id <= issue.id;
      s1_rm <= issue.rm;
      s1_sign <= sign_s0;
      s1_rs1_expo <= rs1_expo_s0;
      s1_rs2_expo <= rs2_expo_s0;
      s1_shift <= rs2_shift;
      s1_special <= special_s0;
      s1_special_result <= special_result_s0;
      s1_invalid <= invalid_s0;
    end
    // mul2
    if (advance[1]) begin
      s2_id <= s1_id;
      s2_rm <= s1_rm;
      s2_sign <= s1_sign;
      s2_expo <= expo_s1;
      s2_special <= s1_special;
      s2_special_result <= s1_special_result;
      s2_invalid <= s1_invalid;
    end
    // output
    if (advance[2]) begin
      id <= s2_id;
      pre_round <= pre_round_d;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/unsigned_multiplier.sv ====
`timescale 1ns/10ps
`default_nettype none

module unsigned_multiplier #(
  parameter int WIDTH = 24
) (
  input  logic clk,
  input  logic rst_n,
  input  logic advance1,
  input  logic advance2,
  input  logic [WIDTH-1:0] rs1,
  input  logic [WIDTH-1:0] rs2,
  output logic [2*WIDTH-1:0] out
);

  logic [WIDTH-1:0] rs1_q;
  logic [WIDTH-1:0] rs2_q;

  // operand regs line up with mul1, product reg with mul2
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rs1_q <= '0;
      rs2_q <= '0;
      out <= '0;
    end else begin
      if (advance1) begin
        rs1_q <= rs1;
        rs2_q <= rs2;
      end
      if (advance2) begin
        out <= rs1_q * rs2_q;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fp_operand_prenormalize.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_operand_prenormalize (
  input  logic [fp_mul_pkg::FLEN-1:0] rs1,
  input  logic [fp_mul_pkg::FLEN-1:0] rs2,
  input  fp_mul_pkg::fp_class_t rs1_cls,
  input  fp_mul_pkg::fp_class_t rs2_cls,
  output logic [fp_mul_pkg::FLEN-1:0] swapped_rs1,
  output logic [fp_mul_pkg::FLEN-1:0] swapped_rs2,
  output logic [fp_mul_pkg::SIG_WIDTH-1:0] rs1_frac,
  output logic [fp_mul_pkg::SIG_WIDTH-1:0] rs2_frac,
  output logic [fp_mul_pkg::EXPO_WIDTH-1:0] rs2_shift
);
  import fp_mul_pkg::*;

  localparam int CNT_WIDTH = $clog2(SIG_WIDTH + 1);

  logic swap;
  logic rs1_hidden;
  logic rs2_hidden;
  logic [SIG_WIDTH-1:0] rs2_sig;
  logic [CNT_WIDTH-1:0] rs2_lz;

  // a lone subnormal always goes to the second slot
  assign swap = rs1_cls.subnormal & ~rs2_cls.subnormal;

  assign swapped_rs1 = swap ? rs2 : rs1;
  assign swapped_rs2 = swap ? rs1 : rs2;
  assign rs1_hidden = swap ? rs2_cls.hidden : rs1_cls.hidden;
  assign rs2_hidden = swap ? rs1_cls.hidden : rs2_cls.hidden;

  assign rs1_frac = {rs1_hidden, swapped_rs1[FRAC_WIDTH-1:0]};
  assign rs2_sig = {rs2_hidden, swapped_rs2[FRAC_WIDTH-1:0]};

  clz #(.WIDTH(SIG_WIDTH)) rs2_clz (
    .clz_input(rs2_sig),
    .clz(rs2_lz)
  );

  // normal operands see a zero shift
  assign rs2_frac = rs2_sig << rs2_lz;
  assign rs2_shift = EXPO_WIDTH'(rs2_lz);

endmodule

`default_nettype wire

// ==== hdl/clz.sv ====
`timescale 1ns/10ps
`default_nettype none

module clz #(
  parameter int WIDTH = 24,
  localparam int CNT_WIDTH = $clog2(WIDTH + 1)
) (
  input  logic [WIDTH-1:0] clz_input,
  output logic [CNT_WIDTH-1:0] clz
);

  // priority encode on the highest set bit
  // later iterations override, so the MSB side wins
  always_comb begin
    clz = CNT_WIDTH'(WIDTH);
    for (int i = 0; i < WIDTH; i++) begin
      if (clz_input[i]) begin
        clz = CNT_WIDTH'(WIDTH - 1 - i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fp_operand_classify.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_operand_classify #(
  parameter bit ENABLE_SUBNORMAL = 1'b1
) (
  input  logic [fp_mul_pkg::FLEN-1:0] operand,
  output fp_mul_pkg::fp_class_t cls
);
  import fp_mul_pkg::*;

  logic [EXPO_WIDTH-1:0] expo;
  logic [FRAC_WIDTH-1:0] frac;
  logic expo_zero;
  logic expo_ones;
  logic frac_zero;

  assign expo = operand[FLEN-2 -: EXPO_WIDTH];
  assign frac = operand[FRAC_WIDTH-1:0];
  assign expo_zero = (expo == '0);
  assign expo_ones = (expo == '1);
  assign frac_zero = (frac == '0);

  // without subnormal support a zero exponent always reads as zero
  assign cls.zero = expo_zero & (frac_zero | !ENABLE_SUBNORMAL);
  assign cls.subnormal = expo_zero & ~frac_zero & ENABLE_SUBNORMAL;
  assign cls.inf = expo_ones & frac_zero;

  // quiet bit is the fraction MSB
  assign cls.qnan = expo_ones & frac[FRAC_WIDTH-1];
  assign cls.snan = expo_ones & ~frac[FRAC_WIDTH-1] & ~frac_zero;

  assign cls.hidden = ~expo_zero;

endmodule

`default_nettype wire

// ==== hdl/fp_mul_pkg.sv ====
`default_nettype none

package fp_mul_pkg;

  //////////////////////////////
  // binary32 format
  localparam int FLEN = 32;
  localparam int EXPO_WIDTH = 8;
  localparam int FRAC_WIDTH = 23;
  localparam int BIAS = 127;

  // significand with hidden bit, and exponent with room for sign and carry
  localparam int SIG_WIDTH = FRAC_WIDTH + 1;
  localparam int EXPO_EXT_WIDTH = EXPO_WIDTH + 2;

  localparam int ID_WIDTH = 3;

  localparam logic [FLEN-1:0] CANONICAL_NAN = 32'h7FC0_0000;

  // RISC-V rm field encoding
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } fp_rm_e;

  // fflags order, nv is the MSB
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

  typedef struct packed {
    logic zero;
    logic inf;
    logic qnan;
    logic snan;
    logic subnormal;
    logic hidden;
  } fp_class_t;

  typedef struct packed {
    logic [FLEN-1:0] rs1;
    logic [FLEN-1:0] rs2;
    fp_rm_e rm;
    logic [ID_WIDTH-1:0] id;
  } fp_issue_t;

  typedef struct packed {
    logic [FLEN-1:0] rd;
    fp_flags_t fflags;
    logic [ID_WIDTH-1:0] id;
  } fp_wb_t;

  // unrounded product handed to the normalize/round stage
  typedef struct packed {
    logic sign;
    logic signed [EXPO_EXT_WIDTH-1:0] expo;
    logic [SIG_WIDTH:0] frac;
    logic [2:0] grs;
    fp_rm_e rm;
    logic special;
    logic [FLEN-1:0] special_result;
    logic invalid;
  } fp_pre_round_t;

endpackage

`default_nettype wire
